// ==== sram_out_top.f ====
+incdir+test
verilog/sram_out_pkg.sv
verilog/word_fifo.sv
verilog/fifo_to_axis.sv
verilog/sram_out_top.sv
test/tb_sram_out_top.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_sram_out_top
FILELIST = sram_out_top.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)

# Every source named in the file list, plus the included testbench tasks
SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS  = $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the binary carries pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_sram_out_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////////////////////////

task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected)
    begin
        $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        $display("Test failed");
        $fatal(1);
    end
endtask

// Sync reset for 10 cycles and clear every queue
task automatic apply_reset();
    @(posedge clk);
    reset      <= 1'b1;
    wr_valid_0 <= 1'b0;
    wr_valid_1 <= 1'b0;
    tready     <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    mon_q.delete();
    exp_q.delete();
    chan_words[0].delete();
    chan_words[1].delete();
    chan_pkts[0].delete();
    chan_pkts[1].delete();
endtask

// Expected stream beat for one memory word
function automatic axis_beat_t make_beat(mem_word_t w, int ch);
    axis_beat_t b;
    b       = '0;
    b.tdata = w.data;
    b.tlast = w.last;
    // Tail word keeps its lowest bytes_m1+1 lanes
    if (w.last)
    begin
        b.tkeep = 8'((9'd1 << (int'(w.bytes_m1) + 1)) - 9'd1);
    end
    else
    begin
        b.tkeep = 8'hff;
    end
    b.tuser[27:24] = w.src_port;
    b.tuser[28]    = (ch == 1);
    return b;
endfunction

task automatic add_packet(int ch, int len, logic [2:0] last_bytes_m1, logic [3:0] port);
    mem_word_t w;
    for (int i = 0; i < len; i++)
    begin
        w.data     = {$random(seed), $random(seed)};
        w.last     = (i == len - 1);
        w.src_port = port;
        // Junk byte count on inner words that the stream ignores
        w.bytes_m1 = (i == len - 1) ? last_bytes_m1 : 3'($random(seed));
        chan_words[ch].push_back(w);
    end
    chan_pkts[ch].push_back(len);
endtask

// Whole packets in round robin order with channel 0 first after reset
task automatic build_expected();
    int next_word [2];
    int next_pkt  [2];
    int last_ch;
    int ch;
    next_word = '{0, 0};
    next_pkt  = '{0, 0};
    last_ch   = 1;
    while (next_pkt[0] < chan_pkts[0].size() || next_pkt[1] < chan_pkts[1].size())
    begin
        ch = 1 - last_ch;
        if (next_pkt[ch] >= chan_pkts[ch].size())
        begin
            ch = last_ch;
        end
        for (int i = 0; i < chan_pkts[ch][next_pkt[ch]]; i++)
        begin
            exp_q.push_back(make_beat(chan_words[ch][next_word[ch]], ch));
            next_word[ch]++;
        end
        next_pkt[ch]++;
        last_ch = ch;
    end
endtask

// Both channels strobe side by side with one word per cycle each
task automatic load_channels();
    int n;
    n = chan_words[0].size();
    if (chan_words[1].size() > n)
    begin
        n = chan_words[1].size();
    end
    for (int i = 0; i < n; i++)
    begin
        @(posedge clk);
        wr_valid_0 <= (i < chan_words[0].size());
        wr_valid_1 <= (i < chan_words[1].size());
        if (i < chan_words[0].size())
        begin
            wr_word_0 <= chan_words[0][i];
        end
        if (i < chan_words[1].size())
        begin
            wr_word_1 <= chan_words[1][i];
        end
    end
    @(posedge clk);
    wr_valid_0 <= 1'b0;
    wr_valid_1 <= 1'b0;
endtask

// Run tready until the monitor holds n beats as counted at the falling edge
task automatic drain_stream(int n, bit random_ready);
    @(negedge clk);
    while (mon_q.size() < n)
    begin
        @(posedge clk);
        tready <= random_ready ? 1'($random(seed)) : 1'b1;
        @(negedge clk);
    end
    @(posedge clk);
    tready <= 1'b0;
endtask

task automatic compare_beats();
    axis_beat_t got;
    axis_beat_t want;
    check_value("beat count", 64'(mon_q.size()), 64'(exp_q.size()));
    while (exp_q.size() > 0)
    begin
        got  = mon_q.pop_front();
        want = exp_q.pop_front();
        check_value("tdata", got.tdata, want.tdata);
        check_value("tkeep", 64'(got.tkeep), 64'(want.tkeep));
        check_value("tlast", 64'(got.tlast), 64'(want.tlast));
        check_value("tuser", 64'(got.tuser), 64'(want.tuser));
    end
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic check_reset_state();
    apply_reset();
    @(negedge clk);
    check_value("tvalid", 64'(tvalid), 64'd0);
    check_value("almost_full_0", 64'(almost_full_0), 64'd0);
    check_value("almost_full_1", 64'(almost_full_1), 64'd0);
    check_value("beats_sent", 64'(beats_sent), 64'd0);
endtask

// Streams while it loads with tready already high
task automatic single_packet();
    apply_reset();
    add_packet(0, 3, 3'd4, 4'h9);
    build_expected();
    @(posedge clk);
    tready <= 1'b1;
    load_channels();
    drain_stream(3, 1'b0);
    @(negedge clk);
    check_value("tkeep", 64'(mon_q[2].tkeep), 64'h1f);
    check_value("tlast", 64'(mon_q[2].tlast), 64'd1);
    check_value("tuser", 64'(mon_q[0].tuser), 64'h0900_0000);
    check_value("beats_sent", 64'(beats_sent), 64'd3);
    compare_beats();
endtask

task automatic round_robin_order();
    int pkt_ch [$];
    apply_reset();
    add_packet(0, 3, 3'd7, 4'h1);
    add_packet(1, 4, 3'd0, 4'h2);
    add_packet(0, 2, 3'd2, 4'h3);
    add_packet(1, 1, 3'd5, 4'h4);
    build_expected();
    load_channels();
    drain_stream(10, 1'b0);
    // Channel tag of each packet's tail beat in stream order
    foreach (mon_q[i])
    begin
        if (mon_q[i].tlast)
        begin
            pkt_ch.push_back(int'(mon_q[i].tuser[28]));
        end
    end
    check_value("packet count", 64'(pkt_ch.size()), 64'd4);
    foreach (pkt_ch[i])
    begin
        check_value("tuser[28]", 64'(pkt_ch[i]), 64'(i % 2));
    end
    compare_beats();
endtask

task automatic random_back_pressure();
    int n_pkts;
    int len;
    int total;
    apply_reset();
    total = 0;
    // At most 3 packets of 4 words per channel stays within almost_full_level
    for (int ch = 0; ch < 2; ch++)
    begin
        n_pkts = 1 + int'($unsigned($random(seed)) % 3);
        for (int p = 0; p < n_pkts; p++)
        begin
            len = 1 + int'($unsigned($random(seed)) % 4);
            add_packet(ch, len, 3'($random(seed)), 4'($random(seed)));
            total += len;
        end
    end
    build_expected();
    load_channels();
    drain_stream(total, 1'b1);
    @(negedge clk);
    check_value("beats_sent", 64'(beats_sent), 64'(total));
    compare_beats();
endtask

task automatic almost_full_flag();
    apply_reset();
    add_packet(1, almost_full_level, 3'd3, 4'hc);
    build_expected();
    // Flag sampled after every write edge while channel 1 fills
    @(posedge clk);
    wr_valid_1 <= 1'b1;
    wr_word_1  <= chan_words[1][0];
    for (int i = 0; i < almost_full_level; i++)
    begin
        @(posedge clk);
        if (i + 1 < almost_full_level)
        begin
            wr_word_1 <= chan_words[1][i + 1];
        end
        else
        begin
            wr_valid_1 <= 1'b0;
        end
        @(negedge clk);
        check_value("almost_full_1", 64'(almost_full_1),
            64'(i + 1 >= almost_full_level));
        check_value("almost_full_0", 64'(almost_full_0), 64'd0);
    end
    drain_stream(almost_full_level, 1'b0);
    @(negedge clk);
    check_value("almost_full_1", 64'(almost_full_1), 64'd0);
    compare_beats();
endtask

// ==== test/tb_sram_out_top.sv ====
`timescale 1ns/1ps

module tb_sram_out_top;
    import sram_out_pkg::*;

    localparam int fifo_depth        = 16;
    localparam int almost_full_level = 12;
    localparam int clk_period        = 10;
    // Beats over all tests, random test at its largest
    localparam int planned_beats     = 3 + 10 + 24 + almost_full_level;
    localparam int watchdog_cycles   = planned_beats * 50;

    logic        clk;
    logic        reset;
    logic        wr_valid_0;
    mem_word_t   wr_word_0;
    logic        almost_full_0;
    logic        wr_valid_1;
    mem_word_t   wr_word_1;
    logic        almost_full_1;
    axis_beat_t  m_axis;
    logic        tvalid;
    logic        tready;
    logic [31:0] beats_sent;

    // Shared by payloads and random tready
    integer seed;

    // Words per channel in write order, with packet lengths
    mem_word_t  chan_words [2][$];
    int         chan_pkts  [2][$];
    // Beats seen on the stream and beats predicted
    axis_beat_t mon_q [$];
    axis_beat_t exp_q [$];

    sram_out_top #(
        .fifo_depth        (fifo_depth),
        .almost_full_level (almost_full_level)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .wr_valid_0    (wr_valid_0),
        .wr_word_0     (wr_word_0),
        .almost_full_0 (almost_full_0),
        .wr_valid_1    (wr_valid_1),
        .wr_word_1     (wr_word_1),
        .almost_full_1 (almost_full_1),
        .m_axis        (m_axis),
        .tvalid        (tvalid),
        .tready        (tready),
        .beats_sent    (beats_sent)
    );

    `include "tb_sram_out_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Clock, monitor, watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // Pre-edge values, so a transfer is what the DUT saw at this edge
    always @(posedge clk)
    begin
        if (!reset && tvalid && tready)
        begin
            mon_q.push_back(m_axis);
        end
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the stream never delivered all beats",
            watchdog_cycles);
        $display("Test failed");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed       = 32'hb7c6_64cc;
        reset      = 1'b1;
        wr_valid_0 = 1'b0;
        wr_word_0  = '0;
        wr_valid_1 = 1'b0;
        wr_word_1  = '0;
        tready     = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_reset_state();
        single_packet();
        round_robin_order();
        random_back_pressure();
        almost_full_flag();

        $display("Test passed");
        $finish;
    end

endmodule

// ==== verilog/sram_out_top.sv ====
`timescale 1ns/1ps

module sram_out_top
#(
    parameter int fifo_depth        = 16,
    parameter int almost_full_level = 12
)
(
    input  logic                     clk,
    input  logic                     reset,
    // Memory read channel 0
    input  logic                     wr_valid_0,
    input  sram_out_pkg::mem_word_t  wr_word_0,
    output logic                     almost_full_0,
    // Memory read channel 1
    input  logic                     wr_valid_1,
    input  sram_out_pkg::mem_word_t  wr_word_1,
    output logic                     almost_full_1,
    // AXI4-Stream master
    output sram_out_pkg::axis_beat_t m_axis,
    output logic                     tvalid,
    input  logic                     tready,
    output logic [31:0]              beats_sent
);
    import sram_out_pkg::*;

    // FIFO heads toward the merge, one slot per channel
    mem_word_t               head [num_channels];
    logic [num_channels-1:0] not_empty;
    logic [num_channels-1:0] pop;

    ////////////////////////////////////////////////////////////////////
    // Per-channel word FIFOs
    ////////////////////////////////////////////////////////////////////

    word_fifo #(
        .fifo_depth        (fifo_depth),
        .almost_full_level (almost_full_level)
    ) fifo0 (
        .clk         (clk),
        .reset       (reset),
        .wr_valid    (wr_valid_0),
        .wr_word     (wr_word_0),
        .pop         (pop[0]),
        .head        (head[0]),
        .not_empty   (not_empty[0]),
        .almost_full (almost_full_0)
    );

    word_fifo #(
        .fifo_depth        (fifo_depth),
        .almost_full_level (almost_full_level)
    ) fifo1 (
        .clk         (clk),
        .reset       (reset),
        .wr_valid    (wr_valid_1),
        .wr_word     (wr_word_1),
        .pop         (pop[1]),
        .head        (head[1]),
        .not_empty   (not_empty[1]),
        .almost_full (almost_full_1)
    );

    // Packet merge onto the stream
    fifo_to_axis merge0 (
        .clk        (clk),
        .reset      (reset),
        .head0      (head[0]),
        .head1      (head[1]),
        .not_empty0 (not_empty[0]),
        .not_empty1 (not_empty[1]),
        .pop0       (pop[0]),
        .pop1       (pop[1]),
        .m_axis     (m_axis),
        .tvalid     (tvalid),
        .tready     (tready),
        .beats_sent (beats_sent)
    );

endmodule

// ==== verilog/fifo_to_axis.sv ====
`timescale 1ns/1ps

module fifo_to_axis
(
    input  logic                     clk,
    input  logic                     reset,
    input  sram_out_pkg::mem_word_t  head0,
    input  sram_out_pkg::mem_word_t  head1,
    input  logic                     not_empty0,
    input  logic                     not_empty1,
    output logic                     pop0,
    output logic                     pop1,
    output sram_out_pkg::axis_beat_t m_axis,
    output logic                     tvalid,
    input  logic                     tready,
    output logic [31:0]              beats_sent
);
    import sram_out_pkg::*;

    localparam int ch_width = $clog2(num_channels);
    // Placement of the tags inside tuser
    localparam int tuser_src_lsb = 24;
    localparam int tuser_ch_lsb  = 28;

    mem_word_t heads [num_channels];
    logic [num_channels-1:0] head_valid;
    logic [num_channels-1:0] pop_vec;

    // Channel hold over a stalled beat and the rest of its packet
    logic                locked;
    logic [ch_width-1:0] lock_ch;
    // Channel that finished the previous packet
    logic [ch_width-1:0] last_ch;
    logic [ch_width-1:0] pref_ch;
    logic [ch_width-1:0] sel;
    mem_word_t           sel_word;
    logic                xfer;

    // Gather the heads by channel number
    assign heads[0]   = head0;
    assign heads[1]   = head1;
    assign head_valid = {not_empty1, not_empty0};

    ////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////

    // Round robin with the channel after the last winner first
    assign pref_ch = last_ch + 1'b1;

    always_comb
    begin
        if (locked)
        begin
            sel = lock_ch;
        end
        else if (head_valid[pref_ch])
        begin
            sel = pref_ch;
        end
        else
        begin
            // Fall back to the other when the preferred one is idle
            sel = last_ch;
        end
    end

    assign sel_word = heads[sel];
    assign tvalid   = head_valid[sel];
    assign xfer     = tvalid && tready;

    ////////////////////////////////////////////////////////////////////
    // Beat forming
    ////////////////////////////////////////////////////////////////////

    always_comb
    begin
        m_axis       = '0;
        m_axis.tdata = sel_word.data;
        m_axis.tlast = sel_word.last;
        // All lanes valid except the tail of a last word
        for (int i = 0; i < word_bytes; i++)
        begin
            m_axis.tkeep[i] = !sel_word.last || (i <= int'(sel_word.bytes_m1));
        end
        m_axis.tuser[tuser_src_lsb +: src_port_width] = sel_word.src_port;
        m_axis.tuser[tuser_ch_lsb +: ch_width]        = sel;
    end

    // Pop the winner in the transfer cycle
    always_comb
    begin
        pop_vec      = '0;
        pop_vec[sel] = xfer;
    end

    assign pop0 = pop_vec[0];
    assign pop1 = pop_vec[1];

    ////////////////////////////////////////////////////////////////////
    // Lock state and beat count
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            locked     <= 1'b0;
            lock_ch    <= '0;
            // Makes channel 0 the first preference
            last_ch    <= ch_width'(num_channels - 1);
            beats_sent <= '0;
        end
        else
        begin
            if (tvalid)
            begin
                if (tready && m_axis.tlast)
                begin
                    // Release and remember the winner once the packet is done
                    locked  <= 1'b0;
                    last_ch <= sel;
                end
                else
                begin
                    // Stay on this channel for a stalled beat or mid-packet
                    locked  <= 1'b1;
                    lock_ch <= sel;
                end
            end
            if (xfer)
            begin
                beats_sent <= beats_sent + 32'd1;
            end
        end
    end

    // Offered beat held steady until accepted
    a_hold_beat: assert property (@(posedge clk) disable iff (reset)
        tvalid && !tready |=> tvalid && $stable(m_axis));

endmodule

// ==== verilog/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo
#(
    parameter int fifo_depth        = 16,
    parameter int almost_full_level = 12
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_valid,
    input  sram_out_pkg::mem_word_t wr_word,
    input  logic                    pop,
    output sram_out_pkg::mem_word_t head,
    output logic                    not_empty,
    output logic                    almost_full
);
    import sram_out_pkg::*;

    localparam int addr_width = $clog2(fifo_depth);
    // Extra wrap bit tells full from empty
    localparam int ptr_width = addr_width + 1;

    // Word storage, circular
    mem_word_t mem [fifo_depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] count;
    logic [ptr_width-1:0] count_next;
    logic                 full;
    logic                 empty;

    ////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////

    // Same slot, wrap bits differ
    assign full = (wr_ptr[addr_width] != rd_ptr[addr_width])
        && (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign not_empty = !empty;

    // Head falls straight through from the array
    assign head = mem[rd_ptr[addr_width-1:0]];

    // Occupancy after this edge
    always_comb
    begin
        case ({wr_valid, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////

    // Array write, no reset on payload
    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            mem[wr_ptr[addr_width-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            if (wr_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // Registered from next count, so it tracks the edge that crosses the level
            almost_full <= (count_next >= ptr_width'(almost_full_level));
        end
    end

    // Memory side must have stopped on almost_full well before this
    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        !(wr_valid && full));

    // Merge pops only a head it presented
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty));

endmodule

// ==== verilog/sram_out_pkg.sv ====
package sram_out_pkg;

    ////////////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////////////

    // Stream data bus, one memory word per beat
    localparam int data_width = 64;
    localparam int word_bytes = data_width / 8;

    // Source-port tag carried with every word
    localparam int src_port_width = 4;

    // Memory read channels feeding the merge
    localparam int num_channels = 2;

    ////////////////////////////////////////////////////////////////////
    // Word and beat formats
    ////////////////////////////////////////////////////////////////////

    // One word as delivered by the memory controller, 72 bits
    typedef struct packed {
        logic [data_width-1:0]         data;
        logic                          last;
        logic [src_port_width-1:0]     src_port;
        // Valid bytes minus one, only meaningful on the last word
        logic [$clog2(word_bytes)-1:0] bytes_m1;
    } mem_word_t;

    // One AXI4-Stream beat on the master side
    typedef struct packed {
        logic [data_width-1:0] tdata;
        logic [word_bytes-1:0] tkeep;
        logic                  tlast;
        // Source port in 27:24, channel number in 28
        logic [31:0]           tuser;
    } axis_beat_t;

endpackage
